// ==== common/vread_bus_pkg.sv ====
`include "vread_defines.svh"

package vread_bus_pkg;

   // databus request, valid and ready travel apart
   typedef struct packed {
      logic [`VREAD_AXI_ADDR_W-1:0] addr;
      logic [`VREAD_LEN_W-1:0]      len;
   } databus_req_t;

   // buffer write port, bank added by the buffer
   typedef struct packed {
      logic                     en;
      logic [`VREAD_IDX_W-1:0]  index;
      logic [`VREAD_DATA_W-1:0] data;
   } buf_wr_t;

   typedef struct packed {
      logic                    en;
      logic [`VREAD_IDX_W-1:0] index;
   } buf_rd_t;

   typedef enum logic [1:0] {
      F_IDLE,
      F_REQ,
      F_DATA
   } fetch_state_e;

   typedef enum logic [1:0] {
      G_IDLE,
      G_DELAY,
      G_RUN
   } gen_state_e;

endpackage

// ==== common/vread_cfg_pkg.sv ====
`include "vread_defines.svh"

package vread_cfg_pkg;

   // burst source, sampled at run
   typedef struct packed {
      logic [`VREAD_AXI_ADDR_W-1:0] ext_addr;
      // zero means no fetch
      logic [`VREAD_LEN_W-1:0]      length;
   } fetch_cfg_t;

   // two-level read pattern
   typedef struct packed {
      logic [`VREAD_ADDR_W-1:0]   start;
      logic [`VREAD_PERIOD_W-1:0] per;
      logic [`VREAD_PERIOD_W-1:0] duty;
      logic [`VREAD_ADDR_W-1:0]   incr;
      // outer passes
      logic [`VREAD_ADDR_W-1:0]   iter;
      // added at the end of each outer pass
      logic [`VREAD_ADDR_W-1:0]   shift;
      logic [`VREAD_DELAY_W-1:0]  delay;
   } gen_cfg_t;

endpackage

// ==== common/vread_defines.svh ====
`ifndef VREAD_DEFINES_SVH
`define VREAD_DEFINES_SVH

// data and external memory words
`define VREAD_DATA_W 32
`define VREAD_AXI_ADDR_W 32

// buffer word address, top bit selects the bank
`define VREAD_ADDR_W 10
`define VREAD_IDX_W (`VREAD_ADDR_W - 1)
`define VREAD_BANK_DEPTH (1 << `VREAD_IDX_W)

// loop and burst fields
`define VREAD_PERIOD_W 8
`define VREAD_DELAY_W 7
`define VREAD_LEN_W 16

`endif

// ==== dv/vread_tb.sv ====
`timescale 1ns/1ps
`include "vread_defines.svh"

module vread_tb;

   localparam int NUM_CASES = 5;
   // most cycles one beat may take, idle gap included
   localparam int MAX_GAP   = 4;
   localparam int EXT_IDX_W = 10;
   localparam int EXT_WORDS = 1 << EXT_IDX_W;

   typedef logic [`VREAD_DATA_W-1:0] word_q_t [$];
   typedef logic [`VREAD_DATA_W-1:0] bank_t [0:`VREAD_BANK_DEPTH-1];

   logic                        clk;
   logic                        rst;
   logic                        run_i;
   logic                        ping_pong_i;
   vread_cfg_pkg::fetch_cfg_t   fetch_cfg_i;
   vread_cfg_pkg::gen_cfg_t     gen_cfg_i;
   logic                        databus_valid_o;
   vread_bus_pkg::databus_req_t databus_req_o;
   logic                        databus_ready_i;
   logic [`VREAD_DATA_W-1:0]    databus_rdata_i;
   logic                        databus_beat_i;
   logic                        databus_last_i;
   logic                        out_valid_o;
   logic [`VREAD_DATA_W-1:0]    out_data_o;
   logic                        done_o;

   vread_cfg_pkg::fetch_cfg_t fetch_cases [NUM_CASES];
   vread_cfg_pkg::gen_cfg_t   gen_cases [NUM_CASES];
   logic                      pp_cases [NUM_CASES];
   string                     case_names [NUM_CASES];

   logic [`VREAD_DATA_W-1:0] ext_mem [EXT_WORDS];
   bank_t                    shadow_lo;
   bank_t                    shadow_hi;
   logic                     bank_state;
   logic [31:0]              rng_state;
   word_q_t                  exp_q;
   string                    test_name;
   int                       expected_total = 0;
   int                       observed_words = 0;
   int                       write_count = 0;

   vread_top i_vread_top (.*);

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic int rand_below(input int bound);
      return int'(next_random() % 32'(bound));
   endfunction

   function automatic vread_cfg_pkg::gen_cfg_t make_gen(input int start, input int per,
      input int duty, input int incr, input int iter, input int shift, input int delay);
      vread_cfg_pkg::gen_cfg_t cfg;
      cfg.start = start[`VREAD_ADDR_W-1:0];
      cfg.per   = per[`VREAD_PERIOD_W-1:0];
      cfg.duty  = duty[`VREAD_PERIOD_W-1:0];
      cfg.incr  = incr[`VREAD_ADDR_W-1:0];
      cfg.iter  = iter[`VREAD_ADDR_W-1:0];
      cfg.shift = shift[`VREAD_ADDR_W-1:0];
      cfg.delay = delay[`VREAD_DELAY_W-1:0];
      return cfg;
   endfunction

   // words read from one bank under the two-level loop
   function automatic word_q_t expected_stream(input vread_cfg_pkg::gen_cfg_t cfg,
      input bank_t bank);
      word_q_t words;
      int      addr;
      words = {};
      for (int o = 0; o < int'(cfg.iter); o++) begin
         for (int i = 0; i < int'(cfg.per); i++) begin
            addr = int'(cfg.start) + o * (int'(cfg.per) * int'(cfg.incr) + int'(cfg.shift))
               + i * int'(cfg.incr);
            if (i < int'(cfg.duty)) begin
               words.push_back(bank[addr[`VREAD_IDX_W-1:0]]);
            end
         end
      end
      return words;
   endfunction

   task automatic stop_on_failure();
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on a failed check");
   endtask

   task automatic fail_value(input string what, input logic [63:0] want, input logic [63:0] got);
      $display("FAIL %s %s expected %0h actual %0h", test_name, what, want, got);
      stop_on_failure();
   endtask

   task automatic fail_text(input string what);
      $display("error in %s: %s", test_name, what);
      stop_on_failure();
   endtask

   task automatic step_busy();
      @(posedge clk);
      assert (done_o === 1'b0) else fail_text("done_o high while the burst is still open");
   endtask

   // memory side of one burst, random wait before ready and random beat gaps
   task automatic serve_burst(input vread_cfg_pkg::fetch_cfg_t cfg, input logic wr_bank);
      vread_bus_pkg::databus_req_t held;
      logic [`VREAD_DATA_W-1:0]    word;
      logic [EXT_IDX_W-1:0]        ext_idx;
      int                          wait_cycles;
      held = databus_req_o;
      assert (held === {cfg.ext_addr, cfg.length})
         else fail_value("request", {cfg.ext_addr, cfg.length}, held);
      wait_cycles = rand_below(6);
      repeat (wait_cycles) begin
         step_busy();
         assert (databus_valid_o === 1'b1) else fail_text("databus_valid_o dropped before ready");
         assert (databus_req_o === held) else fail_value("held request", held, databus_req_o);
      end
      databus_ready_i <= 1'b1;
      step_busy();
      databus_ready_i <= 1'b0;
      for (int k = 0; k < int'(cfg.length); k++) begin
         databus_beat_i <= 1'b0;
         repeat (rand_below(MAX_GAP)) step_busy();
         ext_idx = cfg.ext_addr[EXT_IDX_W+1:2] + EXT_IDX_W'(k);
         word    = ext_mem[ext_idx];
         databus_rdata_i <= word;
         databus_beat_i  <= 1'b1;
         databus_last_i  <= (k == int'(cfg.length) - 1);
         if (wr_bank) begin
            shadow_hi[k] = word;
         end else begin
            shadow_lo[k] = word;
         end
         step_busy();
      end
      databus_beat_i <= 1'b0;
      databus_last_i <= 1'b0;
   endtask

   task automatic run_case(input int idx);
      vread_cfg_pkg::fetch_cfg_t fcfg;
      word_q_t                   words;
      logic                      rd_bank;
      int                        writes_before;
      fcfg       = fetch_cases[idx];
      test_name  = case_names[idx];
      bank_state = pp_cases[idx] ? ~bank_state : 1'b0;
      rd_bank    = pp_cases[idx] ? ~bank_state : 1'b0;
      if (rd_bank) begin
         words = expected_stream(gen_cases[idx], shadow_hi);
      end else begin
         words = expected_stream(gen_cases[idx], shadow_lo);
      end
      foreach (words[n]) begin
         exp_q.push_back(words[n]);
      end
      expected_total += words.size();
      writes_before = write_count;
      @(posedge clk);
      fetch_cfg_i <= fcfg;
      gen_cfg_i   <= gen_cases[idx];
      ping_pong_i <= pp_cases[idx];
      run_i       <= 1'b1;
      @(posedge clk);
      run_i <= 1'b0;
      @(posedge clk);
      assert (done_o === 1'b0) else fail_text("done_o did not fall after run_i");
      assert (databus_valid_o === (fcfg.length != '0))
         else fail_value("databus_valid_o", fcfg.length != '0, databus_valid_o);
      if (fcfg.length != '0) begin
         serve_burst(fcfg, bank_state);
      end
      while (done_o !== 1'b1) begin
         @(posedge clk);
      end
      // one more cycle so a late output word would show up
      repeat (2) @(negedge clk);
      assert (write_count - writes_before == int'(fcfg.length))
         else fail_value("write count", fcfg.length, write_count - writes_before);
      assert (exp_q.size() == 0) else fail_value("words left", 0, exp_q.size());
   endtask

   task automatic load_cases();
      case_names[0]  = "burst_fill";
      pp_cases[0]    = 1'b1;
      fetch_cases[0] = '{32'h0000_0100, 16'd300};
      gen_cases[0]   = make_gen(0, 1, 1, 1, 0, 0, 0);
      case_names[1]  = "pingpong";
      pp_cases[1]    = 1'b1;
      fetch_cases[1] = '{32'h0000_0800, 16'd200};
      gen_cases[1]   = make_gen(0, 4, 4, 1, 50, 0, 0);
      case_names[2]  = "loop_pattern";
      pp_cases[2]    = 1'b1;
      fetch_cases[2] = '{32'h0000_0040, 16'd64};
      gen_cases[2]   = make_gen(5, 6, 3, 2, 8, 7, 9);
      case_names[3]  = "zero_length";
      pp_cases[3]    = 1'b1;
      fetch_cases[3] = '{32'h0000_0000, 16'd0};
      gen_cases[3]   = make_gen(3, 5, 2, 3, 4, 1, 2);
      case_names[4]  = "idle_run";
      pp_cases[4]    = 1'b0;
      fetch_cases[4] = '{32'h0000_0000, 16'd0};
      gen_cases[4]   = make_gen(0, 1, 1, 1, 0, 0, 0);
   endtask

   always @(posedge clk) begin
      if (!rst && out_valid_o === 1'b1) begin
         assert (exp_q.size() > 0) else fail_text("output word arrived with nothing expected");
         assert (out_data_o === exp_q[0]) else fail_value("output word", exp_q[0], out_data_o);
         exp_q.delete(0);
         observed_words++;
      end
   end

   // buffer writes seen inside the DUT
   always @(posedge clk) begin
      if (!rst && i_vread_top.buf_wr.en === 1'b1) begin
         write_count++;
      end
   end

   initial begin : watchdog
      int limit;
      limit = 8;
      @(posedge clk);
      for (int n = 0; n < NUM_CASES; n++) begin
         limit += int'(fetch_cases[n].length) * MAX_GAP + int'(gen_cases[n].delay)
            + int'(gen_cases[n].iter) * int'(gen_cases[n].per) + 100;
      end
      repeat (limit) @(posedge clk);
      $display("test %s timed out after %0d cycles", test_name, limit);
      stop_on_failure();
   end

   initial begin : stimulus
      clk = 1'b0;
      rst <= 1'b1;
      run_i <= 1'b0;
      ping_pong_i <= 1'b0;
      fetch_cfg_i <= '0;
      gen_cfg_i <= '0;
      databus_ready_i <= 1'b0;
      databus_rdata_i <= '0;
      databus_beat_i <= 1'b0;
      databus_last_i <= 1'b0;
      bank_state = 1'b0;
      rng_state = 32'hc43e7bf6;
      for (int a = 0; a < EXT_WORDS; a++) begin
         ext_mem[a] = next_random();
      end
      load_cases();
      test_name = "reset";
      repeat (8) @(posedge clk);
      assert ({done_o, databus_valid_o, out_valid_o} === 3'b100)
         else fail_value("done, valid, out_valid", 3'b100, {done_o, databus_valid_o, out_valid_o});
      rst <= 1'b0;
      for (int n = 0; n < NUM_CASES; n++) begin
         run_case(n);
      end
      if (observed_words == expected_total) begin
         $display("TEST PASS");
         $finish;
      end else begin
         fail_value("total words", expected_total, observed_words);
      end
   end

endmodule

// ==== logic/burst_fetcher.sv ====
`timescale 1ns/1ps
`include "vread_defines.svh"

module burst_fetcher (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        run_i,
   input  vread_cfg_pkg::fetch_cfg_t   cfg_i,
   output logic                        databus_valid_o,
   output vread_bus_pkg::databus_req_t databus_req_o,
   input  logic                        databus_ready_i,
   input  logic [`VREAD_DATA_W-1:0]    databus_rdata_i,
   input  logic                        databus_beat_i,
   input  logic                        databus_last_i,
   output vread_bus_pkg::buf_wr_t      wr_o,
   output logic                        done_o
);

   vread_bus_pkg::fetch_state_e state_q;
   vread_bus_pkg::databus_req_t req_q;
   logic [`VREAD_LEN_W-1:0]     beat_cnt_q;
   logic                        done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q    <= vread_bus_pkg::F_IDLE;
         beat_cnt_q <= '0;
         done_q     <= 1'b1;
      end else if (run_i) begin
         beat_cnt_q <= '0;
         done_q     <= 1'b0;
         // empty burst finishes on the next cycle
         state_q    <= (cfg_i.length == '0) ? vread_bus_pkg::F_IDLE : vread_bus_pkg::F_REQ;
      end else begin
         case (state_q)
            vread_bus_pkg::F_IDLE: begin
               done_q <= 1'b1;
            end
            vread_bus_pkg::F_REQ: begin
               if (databus_ready_i) begin
                  state_q <= vread_bus_pkg::F_DATA;
               end
            end
            vread_bus_pkg::F_DATA: begin
               if (databus_beat_i) begin
                  beat_cnt_q <= beat_cnt_q + 1'b1;
                  if (databus_last_i) begin
                     state_q <= vread_bus_pkg::F_IDLE;
                     done_q  <= 1'b1;
                  end
               end
            end
            default: state_q <= vread_bus_pkg::F_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (run_i) begin
         req_q.addr <= cfg_i.ext_addr;
         req_q.len  <= cfg_i.length;
      end
   end

   assign databus_valid_o = (state_q == vread_bus_pkg::F_REQ);
   assign databus_req_o   = req_q;

   // beats land straight in the buffer
   assign wr_o.en    = (state_q == vread_bus_pkg::F_DATA) && databus_beat_i;
   assign wr_o.index = beat_cnt_q[`VREAD_IDX_W-1:0];
   assign wr_o.data  = databus_rdata_i;
   assign done_o     = done_q;

   // a beat outside the data phase would be lost
   a_no_idle_write: assert property (@(posedge clk) disable iff (rst)
      databus_beat_i |-> state_q == vread_bus_pkg::F_DATA);

   a_index_in_bank: assert property (@(posedge clk) disable iff (rst)
      wr_o.en |-> beat_cnt_q < `VREAD_BANK_DEPTH);

   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      databus_valid_o && !databus_ready_i && !run_i
      |=> databus_valid_o && $stable(databus_req_o));

endmodule

// ==== logic/pingpong_buffer.sv ====
`timescale 1ns/1ps
`include "vread_defines.svh"

module pingpong_buffer (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run_i,
   input  logic                     ping_pong_i,
   input  vread_bus_pkg::buf_wr_t   wr_i,
   input  vread_bus_pkg::buf_rd_t   rd_i,
   input  logic                     fetch_done_i,
   input  logic                     gen_done_i,
   output logic                     out_valid_o,
   output logic [`VREAD_DATA_W-1:0] out_data_o,
   output logic                     done_o
);

   logic [`VREAD_DATA_W-1:0] mem_q [0:(1 << `VREAD_ADDR_W)-1];
   logic                     bank_q;
   logic                     pp_q;
   logic                     wr_bank;
   logic                     rd_bank;
   logic                     out_valid_q;
   logic [`VREAD_DATA_W-1:0] out_data_q;

   // bank flips on every run while ping-pong is on
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q <= 1'b0;
         pp_q   <= 1'b0;
      end else if (run_i) begin
         bank_q <= ping_pong_i ? ~bank_q : 1'b0;
         pp_q   <= ping_pong_i;
      end
   end

   assign wr_bank = bank_q;
   // reader works on the bank filled by the previous run
   assign rd_bank = pp_q ? ~bank_q : 1'b0;

   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem_q[{wr_bank, wr_i.index}] <= wr_i.data;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_i.en) begin
         out_data_q <= mem_q[{rd_bank, rd_i.index}];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= rd_i.en;
      end
   end

   assign out_valid_o = out_valid_q;
   assign out_data_o  = out_data_q;
   assign done_o      = fetch_done_i && gen_done_i;

   // mode input must not turn ping-pong on in the middle of a run
   a_bank_split: assert property (@(posedge clk) disable iff (rst)
      ping_pong_i && wr_i.en && rd_i.en |-> wr_bank != rd_bank);

endmodule

// ==== logic/stride_addr_gen.sv ====
`timescale 1ns/1ps
`include "vread_defines.svh"

module stride_addr_gen (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run_i,
   input  vread_cfg_pkg::gen_cfg_t cfg_i,
   output vread_bus_pkg::buf_rd_t rd_o,
   output logic                   done_o
);

   vread_bus_pkg::gen_state_e  state_q;
   vread_cfg_pkg::gen_cfg_t    cfg_q;
   logic [`VREAD_ADDR_W-1:0]   addr_q;
   logic [`VREAD_PERIOD_W-1:0] in_cnt_q;
   logic [`VREAD_ADDR_W-1:0]   out_cnt_q;
   logic [`VREAD_DELAY_W-1:0]  delay_q;
   logic                       done_q;
   logic                       last_in;
   logic                       last_out;

   assign last_in  = (in_cnt_q == cfg_q.per - 1'b1);
   assign last_out = (out_cnt_q == cfg_q.iter - 1'b1);

   always_ff @(posedge clk) begin
      if (run_i) begin
         cfg_q <= cfg_i;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q   <= vread_bus_pkg::G_IDLE;
         addr_q    <= '0;
         in_cnt_q  <= '0;
         out_cnt_q <= '0;
         delay_q   <= '0;
         done_q    <= 1'b1;
      end else if (run_i) begin
         addr_q    <= cfg_i.start;
         in_cnt_q  <= '0;
         out_cnt_q <= '0;
         delay_q   <= cfg_i.delay;
         done_q    <= 1'b0;
         // nothing to step so finish right away
         if (cfg_i.iter == '0 || cfg_i.per == '0) begin
            state_q <= vread_bus_pkg::G_IDLE;
         end else if (cfg_i.delay == '0) begin
            state_q <= vread_bus_pkg::G_RUN;
         end else begin
            state_q <= vread_bus_pkg::G_DELAY;
         end
      end else begin
         case (state_q)
            vread_bus_pkg::G_IDLE: begin
               done_q <= 1'b1;
            end
            vread_bus_pkg::G_DELAY: begin
               delay_q <= delay_q - 1'b1;
               if (delay_q == 1) begin
                  state_q <= vread_bus_pkg::G_RUN;
               end
            end
            vread_bus_pkg::G_RUN: begin
               if (last_in) begin
                  in_cnt_q <= '0;
                  addr_q   <= addr_q + cfg_q.incr + cfg_q.shift;
                  if (last_out) begin
                     state_q <= vread_bus_pkg::G_IDLE;
                     done_q  <= 1'b1;
                  end else begin
                     out_cnt_q <= out_cnt_q + 1'b1;
                  end
               end else begin
                  in_cnt_q <= in_cnt_q + 1'b1;
                  addr_q   <= addr_q + cfg_q.incr;
               end
            end
            default: state_q <= vread_bus_pkg::G_IDLE;
         endcase
      end
   end

   // reads only on duty steps
   assign rd_o.en    = (state_q == vread_bus_pkg::G_RUN) && (in_cnt_q < cfg_q.duty);
   assign rd_o.index = addr_q[`VREAD_IDX_W-1:0];
   assign done_o     = done_q;

   // reads only while busy and once the start delay has run out
   a_read_in_run: assert property (@(posedge clk) disable iff (rst)
      rd_o.en |-> !done_q && delay_q == '0);

endmodule

// ==== logic/vread_top.sv ====
`timescale 1ns/1ps
`include "vread_defines.svh"

module vread_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        run_i,
   input  logic                        ping_pong_i,
   input  vread_cfg_pkg::fetch_cfg_t   fetch_cfg_i,
   input  vread_cfg_pkg::gen_cfg_t     gen_cfg_i,
   output logic                        databus_valid_o,
   output vread_bus_pkg::databus_req_t databus_req_o,
   input  logic                        databus_ready_i,
   input  logic [`VREAD_DATA_W-1:0]    databus_rdata_i,
   input  logic                        databus_beat_i,
   input  logic                        databus_last_i,
   output logic                        out_valid_o,
   output logic [`VREAD_DATA_W-1:0]    out_data_o,
   output logic                        done_o
);

   vread_bus_pkg::buf_wr_t buf_wr;
   vread_bus_pkg::buf_rd_t buf_rd;
   logic                   fetch_done;
   logic                   gen_done;

   burst_fetcher i_burst_fetcher (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run_i),
      .cfg_i           (fetch_cfg_i),
      .databus_valid_o (databus_valid_o),
      .databus_req_o   (databus_req_o),
      .databus_ready_i (databus_ready_i),
      .databus_rdata_i (databus_rdata_i),
      .databus_beat_i  (databus_beat_i),
      .databus_last_i  (databus_last_i),
      .wr_o            (buf_wr),
      .done_o          (fetch_done)
   );

   stride_addr_gen i_stride_addr_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .cfg_i  (gen_cfg_i),
      .rd_o   (buf_rd),
      .done_o (gen_done)
   );

   pingpong_buffer i_pingpong_buffer (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .ping_pong_i  (ping_pong_i),
      .wr_i         (buf_wr),
      .rd_i         (buf_rd),
      .fetch_done_i (fetch_done),
      .gen_done_i   (gen_done),
      .out_valid_o  (out_valid_o),
      .out_data_o   (out_data_o),
      .done_o       (done_o)
   );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the vread testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module vread_tb -f vread_top.f -o vread_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/vread_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "TEST FAIL" "$log"; then
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi
exit 0

// ==== vread_top.f ====
+incdir+common
common/vread_cfg_pkg.sv
common/vread_bus_pkg.sv
logic/burst_fetcher.sv
logic/stride_addr_gen.sv
logic/pingpong_buffer.sv
logic/vread_top.sv
dv/vread_tb.sv
